// ==== agc_patterns.txt ====
// Per pass: info words 0 to 5 as read from the AGC, then expected scale and offset
// Word 1 is the RMS square, words 2/3 the offset balance, words 4/5 scale and offset
00000011 00040000 00000064 00000064 00000708 00000000 000006EA 00000000
00000022 00010000 00000200 00000100 000006EA 00000000 00000708 FFFFFFE7
00000033 00020000 00000010 00000020 00001000 FFFFFFE7 00000708 00000000
00000044 00040000 00000030 00000035 0000012C 00000000 0000012C 00000000
00000055 00008000 00001000 00000010 0001FBD0 00000064 0001FBD0 0000004B
00000066 00000000 00000000 00000006 0001FBCF FFFFFF00 0001FBED FFFFFF19
00000077 01FFE000 00000007 00000002 0000012D 00000000 0000010F FFFFFF19
00000088 02000000 80000000 00000001 000003E8 00007FF0 00000406 00007FD7
00000099 00021FFF 00000000 FFFFFFF0 00000005 00008000 00000406 FFFF8019
000000AA 00030000 00001234 00001234 00000708 00000000 000006EA FFFF8019

// ==== list.f ====
agc_bus_pkg.sv
agc_loop_pkg.sv
agc_bus_master.sv
agc_step_calc.sv
agc_loop_seq.sv
agc_status_slave.sv
agc_loop_ctrl.sv
agc_module_model.sv
tb_agc_loop_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AGC control loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_agc_loop_ctrl -f list.f -o sim_agc
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_agc > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// ==== tb_agc_loop_ctrl.sv ====
`timescale 1ns/1ps

module tb_agc_loop_ctrl;
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam int NPASS = 10;                          // Lines in the pattern file
    localparam int LIMIT = 2 * BOOT_DELAY + 400 * (NPASS + 2);

    logic        aclk;
    logic        wb_rst_i;
    logic        agc_reset_i;
    logic        hold;
    wb_req_t     up_req_i;
    wb_rsp_t     up_rsp_o;
    wb_req_t     dn_req_o;
    wb_rsp_t     dn_rsp_i;
    info_words_t cur_info;
    bus_dat_t    pat_mem [0:NPASS*8-1];     // Six info words, scale, offset
    int          p;                         // Passes read so far
    int          n_apply;
    int          phase;
    int          rd_idx;
    int          cycles;
    bus_dat_t    exp_sc;
    bus_dat_t    exp_off;

    agc_loop_ctrl UUT (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .up_req_i(up_req_i), .up_rsp_o(up_rsp_o),
        .dn_req_o(dn_req_o), .dn_rsp_i(dn_rsp_i)
    );

    agc_module_model u_model (
        .aclk(aclk), .rst_i(wb_rst_i || agc_reset_i), .hold_i(hold),
        .info_i(cur_info), .req_i(dn_req_o), .rsp_o(dn_rsp_i)
    );

    always_comb begin
        for (int i = 0; i < NUM_INFO; i++)
            cur_info[i] = pat_mem[((p < NPASS) ? p : NPASS - 1) * 8 + i];
    end

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic check_val(input string name, input bus_dat_t got, input bus_dat_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic expect_xfer(input logic we, input bus_adr_t adr, input bus_dat_t dat);
        check_val("dn_req_o.we", 32'(dn_req_o.we), 32'(we));
        check_val("dn_req_o.adr", 32'(dn_req_o.adr), 32'(adr));
        check_val("dn_req_o.sel", 32'(dn_req_o.sel), 32'h0000_000f);   // All byte lanes
        if (we)
            check_val("dn_req_o.dat", dn_req_o.dat, dat);
    endtask

    task automatic up_read(input bus_adr_t adr, output bus_dat_t dat);
        @(posedge aclk);
        up_req_i <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: 4'hf};
        @(posedge aclk);
        while (!up_rsp_o.ack) @(posedge aclk);
        dat = up_rsp_o.dat;
        up_req_i <= '0;                         // Drop stb in the ack cycle
    endtask

    ////////////////////////////////////////////////////////////
    // Downstream bus monitor checks the order of one loop

    always @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            phase   <= 0;
            rd_idx  <= 0;
            exp_sc  <= {15'b0, START_SCALE};
            exp_off <= {{16{START_OFFSET[15]}}, START_OFFSET};
        end else if (dn_req_o.cyc && dn_req_o.stb && dn_rsp_i.ack) begin
            case (phase)
                0: expect_xfer(1'b1, SCALE_ADR, exp_sc);
                1: expect_xfer(1'b1, OFFSET_ADR, exp_off);
                2: expect_xfer(1'b1, CTRL_ADR, CMD_LOAD);
                3: expect_xfer(1'b1, CTRL_ADR, CMD_APPLY);
                4: expect_xfer(1'b1, CTRL_ADR, CMD_RESET);
                5: expect_xfer(1'b1, CTRL_ADR, CMD_START);
                6: expect_xfer(1'b0, CTRL_ADR, '0);     // Status poll
                default: expect_xfer(1'b0, bus_adr_t'(rd_idx * 4), '0);
            endcase
            if (phase < 6) begin
                phase <= phase + 1;
                if (phase == 3)
                    n_apply <= n_apply + 1;
            end else if (phase == 6) begin
                if (dn_rsp_i.dat[DONE_BIT]) begin
                    phase  <= 7;
                    rd_idx <= 0;
                end
            end else if (rd_idx == NUM_INFO - 1) begin
                phase   <= 0;
                exp_sc  <= pat_mem[p * 8 + 6];
                exp_off <= pat_mem[p * 8 + 7];
                p       <= p + 1;
            end else begin
                rd_idx <= rd_idx + 1;
            end
        end
    end

    // Watchdog
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: the control loop did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $fatal(1, "Run ended by watchdog");
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        bus_dat_t rd;
        int       seen;
        int       pidx;
        $readmemh("agc_patterns.txt", pat_mem);
        wb_rst_i    = 1'b1;
        agc_reset_i = 1'b0;
        hold        = 1'b0;
        up_req_i    = '0;
        p           = 0;
        n_apply     = 0;
        cycles      = 0;
        seen        = 0;
        repeat (4) @(posedge aclk);
        wb_rst_i <= 1'b0;
        @(posedge aclk);
        check_val("dn_req_o.cyc", 32'(dn_req_o.cyc), 32'd0);   // Both buses idle out of reset
        check_val("up_rsp_o.ack", 32'(up_rsp_o.ack), 32'd0);

        while (seen < NPASS + 2) begin
            @(posedge aclk);
            if (n_apply != seen) begin
                seen = n_apply;
                if (seen >= 2 && seen <= NPASS + 1) begin
                    hold <= 1'b1;               // Freeze the loop for upstream reads
                    pidx = p - 1;
                    for (int i = 0; i < NUM_INFO; i++) begin
                        up_read(bus_adr_t'(i * 4), rd);
                        check_val($sformatf("up_rsp_o.dat[%0d]", i), rd,
                                  pat_mem[pidx * 8 + ((i < 4) ? i : i + 2)]);
                    end
                    up_read(8'h40, rd);
                    check_val("up_rsp_o.dat scale step", rd, 32'd30);
                    up_read(8'h44, rd);
                    check_val("up_rsp_o.dat offset step", rd, 32'd25);
                    hold <= 1'b0;
                end
                if (seen == NPASS + 1) begin
                    // AGC reset in mid-loop with a request pending
                    @(posedge aclk);
                    while (!dn_req_o.cyc) @(posedge aclk);
                    agc_reset_i <= 1'b1;
                    @(posedge aclk);
                    agc_reset_i <= 1'b0;
                    @(posedge aclk);
                    check_val("dn_req_o.cyc", 32'(dn_req_o.cyc), 32'd0);
                end
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== agc_module_model.sv ====
`timescale 1ns/1ps

module agc_module_model (
    input  logic                      aclk,
    input  logic                      rst_i,
    input  logic                      hold_i,      // Stalls the ack while high
    input  agc_loop_pkg::info_words_t info_i,
    input  agc_bus_pkg::wb_req_t      req_i,
    output agc_bus_pkg::wb_rsp_t      rsp_o
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam logic [31:0] SEED = 32'h97d62e9d;

    logic [31:0] rng;
    logic        busy;          // Request taken, ack not yet given
    logic [1:0]  wait_cnt;
    logic        polling;
    logic [2:0]  polls_left;    // Status reads until done
    logic        ack_q;
    bus_dat_t    rdat_q;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////
    // Register map with random ack delay

    always @(posedge aclk) begin
        if (rst_i) begin
            rng        <= SEED;
            busy       <= 1'b0;
            wait_cnt   <= 2'd0;
            polling    <= 1'b0;
            polls_left <= 3'd0;
            ack_q      <= 1'b0;
            rdat_q     <= '0;
        end else begin
            ack_q <= 1'b0;
            if (ack_q) begin
                busy <= 1'b0;                   // Master drops cyc on this edge
            end else if (!busy) begin
                if (req_i.cyc && req_i.stb) begin
                    busy     <= 1'b1;
                    wait_cnt <= rng[1:0];       // 0 to 3 extra cycles
                    rng      <= xorshift(rng);
                end
            end else if (!hold_i) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    ack_q  <= 1'b1;
                    rdat_q <= '0;
                    if (req_i.we) begin
                        if (req_i.adr == CTRL_ADR && req_i.dat == CMD_START) begin
                            polling    <= 1'b1;
                            polls_left <= 3'd1 + {1'b0, rng[1:0]};
                            rng        <= xorshift(rng);
                        end else if (req_i.adr == CTRL_ADR && req_i.dat == CMD_RESET) begin
                            polling <= 1'b0;
                        end
                    end else if (req_i.adr == CTRL_ADR && polling) begin
                        if (polls_left == 3'd1) begin
                            rdat_q  <= 32'd1 << DONE_BIT;
                            polling <= 1'b0;
                        end else begin
                            polls_left <= polls_left - 3'd1;
                        end
                    end else if (req_i.adr[4:2] < 3'(NUM_INFO)) begin
                        rdat_q <= info_i[req_i.adr[4:2]];
                    end
                end
            end
        end
    end

    assign rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

// ==== agc_loop_ctrl.sv ====
`timescale 1ns/1ps

module agc_loop_ctrl (
    input  logic                 aclk,
    input  logic                 wb_rst_i,
    input  logic                 agc_reset_i,
    input  agc_bus_pkg::wb_req_t up_req_i,
    output agc_bus_pkg::wb_rsp_t up_rsp_o,
    output agc_bus_pkg::wb_req_t dn_req_o,
    input  agc_bus_pkg::wb_rsp_t dn_rsp_i
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    logic        start;
    logic        write;
    bus_adr_t    adr;
    bus_dat_t    wdat;
    logic        done;
    bus_dat_t    rdat;
    logic        calc;
    scale_t      scale;
    offset_t     offset;
    info_words_t info;

    agc_loop_seq u_seq (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .start_o(start), .write_o(write), .adr_o(adr), .wdat_o(wdat),
        .done_i(done), .rdat_i(rdat), .calc_o(calc),
        .scale_i(scale), .offset_i(offset), .info_o(info)
    );

    // Downstream AGC master
    agc_bus_master u_master (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .start_i(start), .write_i(write), .adr_i(adr), .wdat_i(wdat),
        .done_o(done), .rdat_o(rdat), .dn_req_o(dn_req_o), .dn_rsp_i(dn_rsp_i)
    );

    agc_step_calc u_calc (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .calc_i(calc), .info_i(info), .scale_o(scale), .offset_o(offset)
    );

    // Upstream side only sees the bus reset
    agc_status_slave u_slave (
        .aclk(aclk), .wb_rst_i(wb_rst_i),
        .up_req_i(up_req_i), .up_rsp_o(up_rsp_o), .info_i(info)
    );

endmodule

// ==== agc_status_slave.sv ====
`timescale 1ns/1ps

module agc_status_slave (
    input  logic                      aclk,
    input  logic                      wb_rst_i,
    input  agc_bus_pkg::wb_req_t      up_req_i,
    output agc_bus_pkg::wb_rsp_t      up_rsp_o,
    input  agc_loop_pkg::info_words_t info_i
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    slave_state_t state;
    bus_dat_t     rsp_dat;
    logic [3:0]   word_sel;

    assign word_sel = up_req_i.adr[5:2];

    ////////////////////////////////////////////////////////////
    // Upstream slave FSM

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state   <= SLV_IDLE;
            rsp_dat <= '0;
        end else begin
            case (state)
                SLV_IDLE: if (up_req_i.cyc && up_req_i.stb) begin
                    state <= up_req_i.we ? SLV_WRITE : SLV_READ;
                end
                SLV_WRITE: state <= SLV_ACK;    // Nothing writable, just ack
                SLV_READ:  state <= SLV_ACK;
                default:   state <= SLV_IDLE;
            endcase

            if (state == SLV_READ) begin
                if (up_req_i.adr[6]) begin
                    // Loop step sizes
                    case (word_sel)
                        4'd0: rsp_dat <= {15'b0, SCALE_DELTA};
                        4'd1: rsp_dat <= {{16{OFFSET_DELTA[15]}}, OFFSET_DELTA};
                        default: ;
                    endcase
                end else if (word_sel < 4'(NUM_INFO)) begin
                    rsp_dat <= info_i[word_sel[2:0]];
                end else begin
                    rsp_dat <= '0;      // Past the info store
                end
            end
        end
    end

    assign up_rsp_o = '{ack: (state == SLV_ACK), dat: rsp_dat};

endmodule

// ==== agc_loop_seq.sv ====
`timescale 1ns/1ps

module agc_loop_seq (
    input  logic                      aclk,
    input  logic                      wb_rst_i,
    input  logic                      agc_reset_i,
    output logic                      start_o,
    output logic                      write_o,
    output agc_bus_pkg::bus_adr_t     adr_o,
    output agc_bus_pkg::bus_dat_t     wdat_o,
    input  logic                      done_i,
    input  agc_bus_pkg::bus_dat_t     rdat_i,
    output logic                      calc_o,
    input  agc_loop_pkg::scale_t      scale_i,
    input  agc_loop_pkg::offset_t     offset_i,
    output agc_loop_pkg::info_words_t info_o
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    loop_state_t           loop_state;
    comm_state_t           comm_state;
    logic [2:0]            info_idx;    // Info word, or 0/1 for scale/offset write
    logic [BOOT_CNT_W-1:0] boot_cnt;
    info_words_t           info_q;
    bus_dat_t              scale_word;
    bus_dat_t              offset_word;
    logic                  req_we;
    bus_adr_t              req_adr;
    bus_dat_t              req_dat;

    assign scale_word  = {15'b0, scale_i};
    assign offset_word = {{16{offset_i[15]}}, offset_i};
    assign calc_o      = (loop_state == LOOP_CALCULATING);
    assign info_o      = info_q;

    ////////////////////////////////////////////////////////////
    // Transaction for the current step

    always_comb begin
        req_we  = 1'b1;
        req_adr = CTRL_ADR;
        req_dat = '0;
        case (loop_state)
            LOOP_RESETTING: req_dat = CMD_RESET;
            LOOP_POLLING:   req_dat = CMD_START;
            LOOP_WAITING:   req_we  = 1'b0;     // Status read
            LOOP_READING: begin
                req_we  = 1'b0;
                req_adr = bus_adr_t'({info_idx, 2'b00});
            end
            LOOP_WRITING: begin
                req_adr = (info_idx == 3'd0) ? SCALE_ADR : OFFSET_ADR;
                req_dat = (info_idx == 3'd0) ? scale_word : offset_word;
            end
            LOOP_LOADING:   req_dat = CMD_LOAD;
            LOOP_APPLYING:  req_dat = CMD_APPLY;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control loop FSM

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            loop_state <= LOOP_BOOT_DELAY;
            comm_state <= COMM_SENDING;
            info_idx   <= '0;
            boot_cnt   <= BOOT_CNT_W'(BOOT_DELAY);
            start_o    <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (loop_state == LOOP_BOOT_DELAY) begin
                if (boot_cnt != '0) begin
                    boot_cnt <= boot_cnt - 1'b1;
                end else begin
                    loop_state <= LOOP_WRITING;     // Start values first
                    info_idx   <= '0;
                end
            end else if (loop_state == LOOP_CALCULATING) begin
                loop_state <= LOOP_WRITING;         // Calculator registers this edge
                info_idx   <= '0;
            end else begin
                case (comm_state)
                    COMM_SENDING: begin
                        start_o    <= 1'b1;
                        comm_state <= COMM_WAITING;
                    end
                    COMM_WAITING: if (done_i) comm_state <= COMM_PROCESSING;
                    default: begin
                        comm_state <= COMM_SENDING;
                        case (loop_state)
                            LOOP_RESETTING: loop_state <= LOOP_POLLING;
                            LOOP_POLLING:   loop_state <= LOOP_WAITING;
                            LOOP_WAITING: if (rdat_i[DONE_BIT]) begin
                                loop_state <= LOOP_READING;
                                info_idx   <= '0;
                            end
                            LOOP_READING: begin
                                if (info_idx == 3'(NUM_INFO - 1)) loop_state <= LOOP_CALCULATING;
                                else info_idx <= info_idx + 3'd1;
                            end
                            LOOP_WRITING: begin
                                if (info_idx == 3'd0) info_idx <= 3'd1;
                                else loop_state <= LOOP_LOADING;
                            end
                            LOOP_LOADING:   loop_state <= LOOP_APPLYING;
                            LOOP_APPLYING:  loop_state <= LOOP_RESETTING;
                            default:        loop_state <= LOOP_BOOT_DELAY;
                        endcase
                    end
                endcase
            end
        end
    end

    // Request words latch while idle, master picks them up with start
    always_ff @(posedge aclk) begin
        if (comm_state == COMM_SENDING) begin
            write_o <= req_we;
            adr_o   <= req_adr;
            wdat_o  <= req_dat;
        end
    end

    // Info store
    always_ff @(posedge aclk) begin
        if (comm_state == COMM_PROCESSING && loop_state == LOOP_READING)
            info_q[info_idx] <= rdat_i;
        if (comm_state == COMM_PROCESSING && loop_state == LOOP_APPLYING) begin
            info_q[4] <= scale_word;    // Applied values as written
            info_q[5] <= offset_word;
        end
    end

    a_legal_state: assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        (loop_state inside {LOOP_BOOT_DELAY, LOOP_RESETTING, LOOP_POLLING, LOOP_WAITING,
                            LOOP_READING, LOOP_CALCULATING, LOOP_WRITING, LOOP_LOADING,
                            LOOP_APPLYING}) && (info_idx < 3'(NUM_INFO)));

endmodule

// ==== agc_step_calc.sv ====
`timescale 1ns/1ps

module agc_step_calc (
    input  logic                      aclk,
    input  logic                      wb_rst_i,
    input  logic                      agc_reset_i,
    input  logic                      calc_i,
    input  agc_loop_pkg::info_words_t info_i,
    output agc_loop_pkg::scale_t      scale_o,
    output agc_loop_pkg::offset_t     offset_o
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    rms_sq_t rms_sq;
    scale_t  cur_scale;     // Scale read back from the AGC
    offset_t cur_offset;
    scale_t  scale_d;
    offset_t offset_d;

    assign rms_sq     = rms_sq_t'(info_i[1] >> (17 - REDUCTION_BITS));
    assign cur_scale  = info_i[4][16:0];
    assign cur_offset = info_i[5][15:0];

    ////////////////////////////////////////////////////////////
    // Fixed step rule

    always_comb begin
        scale_d = scale_o;      // Dead band keeps the last value
        if (rms_sq > rms_sq_t'(TARGET_RMS_SQ + RMS_SQ_ERR)) begin
            // Too loud, back the gain off
            scale_d = (cur_scale > SCALE_MIN_CUT) ? cur_scale - SCALE_DELTA : cur_scale;
        end else if (rms_sq < rms_sq_t'(TARGET_RMS_SQ - RMS_SQ_ERR)) begin
            scale_d = (cur_scale < SCALE_MAX_CUT) ? cur_scale + SCALE_DELTA : cur_scale;
        end
    end

    // Offset follows the balance of words 2 and 3
    always_comb begin
        offset_d = offset_o;
        if (info_i[2] > info_i[3] + bus_dat_t'(OFFSET_ERR))
            offset_d = cur_offset - OFFSET_DELTA;
        else if (info_i[3] > info_i[2] + bus_dat_t'(OFFSET_ERR))
            offset_d = cur_offset + OFFSET_DELTA;
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            scale_o  <= START_SCALE;
            offset_o <= START_OFFSET;
        end else if (calc_i) begin
            scale_o  <= scale_d;
            offset_o <= offset_d;
        end
    end

endmodule

// ==== agc_bus_master.sv ====
`timescale 1ns/1ps

module agc_bus_master (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  agc_reset_i,
    input  logic                  start_i,
    input  logic                  write_i,
    input  agc_bus_pkg::bus_adr_t adr_i,
    input  agc_bus_pkg::bus_dat_t wdat_i,
    output logic                  done_o,
    output agc_bus_pkg::bus_dat_t rdat_o,
    output agc_bus_pkg::wb_req_t  dn_req_o,
    input  agc_bus_pkg::wb_rsp_t  dn_rsp_i
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    comm_state_t comm_state;
    logic        req_act;       // Drives cyc, stb and sel together
    logic        req_we;
    bus_adr_t    req_adr;
    bus_dat_t    req_dat;

    // Control side of the transaction
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            comm_state <= COMM_SENDING;
            req_act    <= 1'b0;
            req_we     <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (comm_state)
                COMM_SENDING: if (start_i) begin
                    req_act    <= 1'b1;
                    req_we     <= write_i;
                    comm_state <= COMM_WAITING;
                end
                COMM_WAITING: if (dn_rsp_i.ack) begin   // Target took it
                    req_act    <= 1'b0;
                    req_we     <= 1'b0;
                    done_o     <= 1'b1;
                    comm_state <= COMM_SENDING;
                end
                default: comm_state <= COMM_SENDING;
            endcase
        end
    end

    // Address, write word and captured read word
    always_ff @(posedge aclk) begin
        if (comm_state == COMM_SENDING && start_i) begin
            req_adr <= adr_i;
            req_dat <= write_i ? wdat_i : '0;
        end
        if (comm_state == COMM_WAITING && dn_rsp_i.ack)
            rdat_o <= dn_rsp_i.dat;
    end

    assign dn_req_o = '{cyc: req_act, stb: req_act, we: req_we, adr: req_adr,
                        dat: req_dat, sel: {$bits(bus_sel_t){req_act}}};

    // Sequencer must wait for done before the next start
    a_one_in_flight: assert property (@(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        start_i |-> !dn_req_o.cyc);

endmodule

// ==== agc_loop_pkg.sv ====
package agc_loop_pkg;

    ////////////////////////////////////////////////////////////
    // Loop constants

    localparam int NUM_INFO       = 6;         // Info words kept per pass
    localparam int DONE_BIT       = 1;         // Sample cycle done in status word
    localparam int BOOT_DELAY     = 31;
    localparam int BOOT_CNT_W     = $clog2(BOOT_DELAY + 1);
    localparam int REDUCTION_BITS = 4;
    localparam int TARGET_RMS_SQ  = 16;
    localparam int RMS_SQ_ERR     = 0;
    localparam int OFFSET_ERR     = 5;

    // Downstream AGC register map
    localparam agc_bus_pkg::bus_adr_t CTRL_ADR   = 8'h00;
    localparam agc_bus_pkg::bus_adr_t SCALE_ADR  = 8'h10;
    localparam agc_bus_pkg::bus_adr_t OFFSET_ADR = 8'h14;

    // Commands written to the control register
    localparam agc_bus_pkg::bus_dat_t CMD_START = 32'h0000_0001;
    localparam agc_bus_pkg::bus_dat_t CMD_RESET = 32'h0000_0004;
    localparam agc_bus_pkg::bus_dat_t CMD_LOAD  = 32'h0000_0300;  // Load scale and offset
    localparam agc_bus_pkg::bus_dat_t CMD_APPLY = 32'h0000_0400;

    ////////////////////////////////////////////////////////////
    // Value types

    typedef logic [16:0]        scale_t;    // Unsigned AGC gain
    typedef logic signed [15:0] offset_t;
    typedef logic [11:0]        rms_sq_t;   // Reduced RMS square
    typedef agc_bus_pkg::bus_dat_t [NUM_INFO-1:0] info_words_t;

    localparam scale_t  START_SCALE   = 17'd1800;
    localparam offset_t START_OFFSET  = 16'sd0;
    localparam scale_t  SCALE_DELTA   = 17'd30;
    localparam offset_t OFFSET_DELTA  = 16'sd25;
    localparam scale_t  SCALE_MIN_CUT = 17'h0012C;
    localparam scale_t  SCALE_MAX_CUT = 17'h1FBD0;

    ////////////////////////////////////////////////////////////
    // State machines

    typedef enum logic [3:0] {
        LOOP_BOOT_DELAY,
        LOOP_RESETTING,
        LOOP_POLLING,
        LOOP_WAITING,
        LOOP_READING,
        LOOP_CALCULATING,
        LOOP_WRITING,
        LOOP_LOADING,
        LOOP_APPLYING
    } loop_state_t;

    typedef enum logic [1:0] {COMM_SENDING, COMM_WAITING, COMM_PROCESSING} comm_state_t;

    typedef enum logic [1:0] {SLV_IDLE, SLV_WRITE, SLV_READ, SLV_ACK} slave_state_t;

endpackage

// ==== agc_bus_pkg.sv ====
package agc_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Wishbone field types

    typedef logic [7:0]  bus_adr_t;     // Byte address, 8 bits on both buses
    typedef logic [31:0] bus_dat_t;     // One bus word
    typedef logic [3:0]  bus_sel_t;     // Byte lanes of a bus word

    ////////////////////////////////////////////////////////////
    // Request and response bundles

    // Request from master to target
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        bus_adr_t adr;
        bus_dat_t dat;
        bus_sel_t sel;
    } wb_req_t;

    // Response from target back to master
    typedef struct packed {
        logic     ack;
        bus_dat_t dat;      // Read word, valid with ack
    } wb_rsp_t;

endpackage
